/* hdl/fpga_bus_pkg.sv */
package fpga_bus_pkg;

    // --------------------------------------------------------------------------
    // board sizes
    // --------------------------------------------------------------------------
    localparam int NUM_MOTORS   = 4;            // motor channels 1..NUM_MOTORS
    localparam int NUM_ENCODERS = 4;            // encoder channels

    // real-time block read layout, in quadlets
    localparam int RT_STATUS_QUADS = 4;         // board status words first
    localparam int RT_MOTOR_QUADS  = 2;         // per motor
    localparam int RT_ENC_QUADS    = 5;         // per encoder
    localparam int NUM_RT_READ_QUADS = RT_STATUS_QUADS + RT_MOTOR_QUADS*NUM_MOTORS
                                     + RT_ENC_QUADS*NUM_ENCODERS;
    localparam int RT_IDX_W = $clog2(NUM_RT_READ_QUADS);    // block index width

    localparam int RT_CNT_W = $clog2(NUM_MOTORS + 1);       // quadlet count, saturates

    // --------------------------------------------------------------------------
    // address map
    // --------------------------------------------------------------------------
    // addr[15:12] page, addr[7:4] channel, addr[3:0] register
    localparam logic [3:0] ADDR_MAIN = 4'd0;
    localparam logic [3:0] ADDR_HUB  = 4'd2;

    // main page, channel 0
    localparam logic [3:0] REG_STATUS  = 4'd0;
    localparam logic [3:0] REG_VERSION = 4'd1;
    localparam logic [3:0] REG_WDOG    = 4'd2;  // watchdog period, WDOG_TICK units
    localparam logic [3:0] REG_SCRATCH = 4'd3;

    localparam logic [3:0] REG_DAC = 4'd0;      // motor command, channels 1..N

    localparam logic [31:0] FW_VERSION = 32'h0000_0007;

    localparam int WDOG_TICK   = 16;            // cycles per period unit
    localparam int WDOG_TICK_W = $clog2(WDOG_TICK);

    localparam int HUB_DEPTH = 16;
    localparam int HUB_IDX_W = $clog2(HUB_DEPTH);

    // --------------------------------------------------------------------------
    // bus types
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [15:0] addr;                      // block index when blk_rt is set
        logic        blk_rt;
    } rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;                      // final quadlet of the block
    } rt_quad_t;

    function automatic logic [15:0] make_addr(input logic [3:0] page,
                                              input logic [3:0] chan,
                                              input logic [3:0] regi);
        return {page, 4'h0, chan, regi};
    endfunction

    // main page channel 0 holds the board registers
    function automatic logic is_board_addr(input logic [15:0] addr);
        return (addr[15:12] == ADDR_MAIN) && (addr[7:4] == 4'd0);
    endfunction

endpackage

/* hdl/rt_write_unpack.sv */
`timescale 1ns/1ps

module rt_write_unpack (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic                   rt_valid,
    output logic                   rt_ready,
    input  fpga_bus_pkg::rt_quad_t rt,
    output logic                   uw_valid,
    output fpga_bus_pkg::reg_wr_t  uw,
    output logic                   blk_done
);
    import fpga_bus_pkg::*;

    logic [RT_CNT_W-1:0] quad_cnt;              // quadlet index within the block
    logic                rt_take;
    logic                in_range;              // still a motor left for this quadlet
    logic [3:0]          motor_chan;

    // never stalls
    // one write per quadlet, and the arbiter always grants this path
    assign rt_ready = 1'b1;

    assign rt_take    = rt_valid && rt_ready;
    assign in_range   = (quad_cnt < RT_CNT_W'(NUM_MOTORS));
    assign motor_chan = 4'(quad_cnt) + 4'd1;    // quadlet k -> channel k+1

    // --------------------------------------------------------------------------
    // block position and control
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            quad_cnt <= '0;
            uw_valid <= 1'b0;
            blk_done <= 1'b0;
        end else begin
            uw_valid <= rt_take && in_range;    // extra quadlets produce nothing
            blk_done <= rt_take && rt.last;     // one-cycle pulse

            if (rt_take) begin
                if (rt.last) begin
                    quad_cnt <= '0;             // ready for the next block
                end else if (in_range) begin
                    quad_cnt <= quad_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // write payload
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rt_take && in_range) begin
            uw.addr <= make_addr(ADDR_MAIN, motor_chan, REG_DAC);
            uw.data <= rt.data;
        end
    end

endmodule

/* hdl/write_bus_arbiter.sv */
`timescale 1ns/1ps

module write_bus_arbiter (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic                  uw_valid,     // unpacker write, wins every time
    input  fpga_bus_pkg::reg_wr_t uw,
    input  logic                  wr_valid,     // host write
    output logic                  wr_ready,
    input  fpga_bus_pkg::reg_wr_t wr,
    output logic                  bus_wen,
    output fpga_bus_pkg::reg_wr_t bus_wr,
    output logic                  host_wr
);
    import fpga_bus_pkg::*;

    logic host_take;

    // host waits while the real-time path owns this cycle
    assign wr_ready  = !uw_valid;
    assign host_take = wr_valid && wr_ready;

    // --------------------------------------------------------------------------
    // write bus mux
    // --------------------------------------------------------------------------
    always_comb begin
        if (uw_valid) begin
            bus_wen = 1'b1;
            bus_wr  = uw;
        end else begin
            bus_wen = host_take;
            bus_wr  = wr;
        end
    end

    // host activity flag for the watchdog
    // one cycle behind the transfer, so the unpacker cannot restart the count
    always_ff @(posedge sysclk) begin
        if (rst) begin
            host_wr <= 1'b0;
        end else begin
            host_wr <= host_take;
        end
    end

endmodule

/* hdl/read_addr_xlate.sv */
`timescale 1ns/1ps

module read_addr_xlate (
    input  fpga_bus_pkg::rd_req_t rd,
    output logic [15:0]           raddr
);
    import fpga_bus_pkg::*;

    localparam int MOTOR_END = RT_STATUS_QUADS + RT_MOTOR_QUADS*NUM_MOTORS;

    logic [RT_IDX_W-1:0] idx;                   // block read index
    logic [RT_IDX_W-1:0] j;                     // offset into the motor region
    logic [RT_IDX_W-1:0] m;                     // offset into the encoder region

    assign idx = rd.addr[RT_IDX_W-1:0];
    assign j   = idx - RT_IDX_W'(RT_STATUS_QUADS);
    assign m   = idx - RT_IDX_W'(MOTOR_END);

    // --------------------------------------------------------------------------
    // index regions: board status, motor pairs, encoder groups of five
    // --------------------------------------------------------------------------
    always_comb begin
        if (!rd.blk_rt) begin
            raddr = rd.addr;                    // ordinary read, untouched
        end else if (idx < RT_IDX_W'(RT_STATUS_QUADS)) begin
            raddr = make_addr(ADDR_MAIN, 4'd0, 4'(idx));
        end else if (idx < RT_IDX_W'(MOTOR_END)) begin
            // two quadlets per motor, registers 1 and 2
            raddr = make_addr(ADDR_MAIN, 4'(j >> 1) + 4'd1, {3'd0, j[0]} + 4'd1);
        end else begin
            // five quadlets per encoder, registers 4..8
            raddr = make_addr(ADDR_MAIN, 4'(m / RT_ENC_QUADS) + 4'd1,
                              4'(m % RT_ENC_QUADS) + 4'd4);
        end
    end

endmodule

/* hdl/board_regs.sv */
`timescale 1ns/1ps

module board_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic [3:0]            board_id,     // rotary switch
    input  logic                  bus_wen,
    input  fpga_bus_pkg::reg_wr_t bus_wr,
    input  logic                  host_wr,      // restarts the watchdog
    input  logic [15:0]           raddr,
    output logic [31:0]           rdata,
    input  logic                  wdog_clear,
    output logic                  wdog_timeout
);
    import fpga_bus_pkg::*;

    logic [15:0]            wdog_period;        // 0 disarms the watchdog
    logic [31:0]            scratch;
    logic [WDOG_TICK_W-1:0] tick_cnt;           // cycles within one period unit
    logic [15:0]            unit_cnt;           // elapsed period units
    logic                   board_wen;
    logic                   status_wr;
    logic                   armed;
    logic                   tick_wrap;
    logic                   expire;

    assign board_wen = bus_wen && is_board_addr(bus_wr.addr);
    assign status_wr = board_wen && (bus_wr.addr[3:0] == REG_STATUS);

    assign armed     = (wdog_period != 16'd0);
    assign tick_wrap = (tick_cnt == WDOG_TICK_W'(WDOG_TICK - 1));
    assign expire    = armed && tick_wrap && (unit_cnt == wdog_period - 16'd1);

    // --------------------------------------------------------------------------
    // writable registers
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wdog_period <= 16'd0;
        end else if (board_wen && (bus_wr.addr[3:0] == REG_WDOG)) begin
            wdog_period <= bus_wr.data[15:0];
        end
    end

    always_ff @(posedge sysclk) begin
        if (board_wen && (bus_wr.addr[3:0] == REG_SCRATCH)) begin
            scratch <= bus_wr.data;
        end
    end

    // --------------------------------------------------------------------------
    // watchdog
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            tick_cnt     <= '0;
            unit_cnt     <= 16'd0;
            wdog_timeout <= 1'b0;
        end else begin
            // host traffic, disarmed or already expired all park the count at 0
            if (host_wr || !armed || wdog_timeout) begin
                tick_cnt <= '0;
                unit_cnt <= 16'd0;
            end else if (tick_wrap) begin
                tick_cnt <= '0;
                unit_cnt <= unit_cnt + 16'd1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (wdog_clear || status_wr) begin
                wdog_timeout <= 1'b0;
            end else if (expire && !host_wr) begin
                wdog_timeout <= 1'b1;           // sticky until cleared
            end
        end
    end

    // --------------------------------------------------------------------------
    // read mux
    // --------------------------------------------------------------------------
    always_comb begin
        rdata = 32'd0;
        if (is_board_addr(raddr)) begin
            case (raddr[3:0])
                REG_STATUS:  rdata = {4'd0, board_id, 23'd0, wdog_timeout};
                REG_VERSION: rdata = FW_VERSION;
                REG_WDOG:    rdata = {16'd0, wdog_period};
                REG_SCRATCH: rdata = scratch;
                default:     rdata = 32'd0;     // unmodelled status words
            endcase
        end
    end

endmodule

/* hdl/hub_regs.sv */
`timescale 1ns/1ps

module hub_regs (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic                  bus_wen,
    input  fpga_bus_pkg::reg_wr_t bus_wr,
    input  logic                  blk_done,     // one pulse per real-time block
    input  logic [15:0]           raddr,
    output logic [31:0]           rdata
);
    import fpga_bus_pkg::*;

    localparam logic [HUB_IDX_W-1:0] SEQ_IDX = HUB_IDX_W'(HUB_DEPTH - 1);

    logic [31:0]          hub_mem [HUB_DEPTH];  // broadcast quadlets
    logic [15:0]          bc_sequence;
    logic                 hub_wen;
    logic [HUB_IDX_W-1:0] widx;
    logic [HUB_IDX_W-1:0] ridx;

    assign hub_wen = bus_wen && (bus_wr.addr[15:12] == ADDR_HUB);
    assign widx    = bus_wr.addr[HUB_IDX_W-1:0];
    assign ridx    = raddr[HUB_IDX_W-1:0];

    // --------------------------------------------------------------------------
    // quadlet memory
    // --------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (hub_wen) begin
            hub_mem[widx] <= bus_wr.data;       // last entry is shadowed by the sequence
        end
    end

    // broadcast sequence, counts finished blocks
    always_ff @(posedge sysclk) begin
        if (rst) begin
            bc_sequence <= 16'd0;
        end else if (blk_done) begin
            bc_sequence <= bc_sequence + 16'd1; // wraps
        end
    end

    // asynchronous read, response register sits in the top level
    always_comb begin
        if (ridx == SEQ_IDX) begin
            rdata = {16'd0, bc_sequence};
        end else begin
            rdata = hub_mem[ridx];
        end
    end

endmodule

/* hdl/reg_bus_core.sv */
`timescale 1ns/1ps

module reg_bus_core (
    input  logic                   sysclk,
    input  logic                   rst,
    input  logic [3:0]             board_id,

    // host write port
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  fpga_bus_pkg::reg_wr_t  wr,

    // real-time block write stream
    input  logic                   rt_valid,
    output logic                   rt_ready,
    input  fpga_bus_pkg::rt_quad_t rt,

    // host read request and response
    input  logic                   rd_valid,
    output logic                   rd_ready,
    input  fpga_bus_pkg::rd_req_t  rd,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [31:0]            rsp_data,

    // external channel port
    output logic                   ext_wen,
    output fpga_bus_pkg::reg_wr_t  ext_wr,
    output logic [15:0]            ext_raddr,
    input  logic [31:0]            ext_rdata,   // combinational, same cycle

    input  logic                   wdog_clear,
    output logic                   wdog_timeout
);
    import fpga_bus_pkg::*;

    logic        uw_valid;                      // unpacker -> arbiter
    reg_wr_t     uw;
    logic        blk_done;
    logic        bus_wen;                       // merged write bus
    reg_wr_t     bus_wr;
    logic        host_wr;
    logic [15:0] raddr;                         // translated read address
    logic [31:0] board_rdata;
    logic [31:0] hub_rdata;
    logic [31:0] rd_mux;
    logic        rd_take;

    // --------------------------------------------------------------------------
    // write side
    // --------------------------------------------------------------------------
    rt_write_unpack unpack (
        .sysclk   (sysclk),
        .rst      (rst),
        .rt_valid (rt_valid),
        .rt_ready (rt_ready),
        .rt       (rt),
        .uw_valid (uw_valid),
        .uw       (uw),
        .blk_done (blk_done)
    );

    write_bus_arbiter arb (
        .sysclk   (sysclk),
        .rst      (rst),
        .uw_valid (uw_valid),
        .uw       (uw),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr       (wr),
        .bus_wen  (bus_wen),
        .bus_wr   (bus_wr),
        .host_wr  (host_wr)
    );

    // everything outside the board registers and the hub goes off chip
    assign ext_wen = bus_wen && !is_board_addr(bus_wr.addr)
                     && (bus_wr.addr[15:12] != ADDR_HUB);
    assign ext_wr  = bus_wr;

    // --------------------------------------------------------------------------
    // register blocks
    // --------------------------------------------------------------------------
    board_regs chan0 (
        .sysclk       (sysclk),
        .rst          (rst),
        .board_id     (board_id),
        .bus_wen      (bus_wen),
        .bus_wr       (bus_wr),
        .host_wr      (host_wr),
        .raddr        (raddr),
        .rdata        (board_rdata),
        .wdog_clear   (wdog_clear),
        .wdog_timeout (wdog_timeout)
    );

    hub_regs hub (
        .sysclk   (sysclk),
        .rst      (rst),
        .bus_wen  (bus_wen),
        .bus_wr   (bus_wr),
        .blk_done (blk_done),
        .raddr    (raddr),
        .rdata    (hub_rdata)
    );

    // --------------------------------------------------------------------------
    // read side
    // --------------------------------------------------------------------------
    read_addr_xlate xlate (
        .rd    (rd),
        .raddr (raddr)
    );

    assign ext_raddr = raddr;

    always_comb begin
        if (raddr[15:12] == ADDR_HUB) begin
            rd_mux = hub_rdata;
        end else if (is_board_addr(raddr)) begin
            rd_mux = board_rdata;
        end else begin
            rd_mux = ext_rdata;
        end
    end

    // single response slot, refilled in the cycle it drains
    assign rd_ready = !rsp_valid || rsp_ready;
    assign rd_take  = rd_valid && rd_ready;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (rd_take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;                  // consumed
        end
    end

    always_ff @(posedge sysclk) begin
        if (rd_take) begin
            rsp_data <= rd_mux;
        end
    end

endmodule

/* tb/reg_bus_core_tb.sv */
`timescale 1ns/1ps

module reg_bus_core_tb;
    import fpga_bus_pkg::*;

    localparam logic [3:0] BOARD_ID = 4'hA;

    logic        sysclk;
    logic        rst;
    logic        wr_valid;
    logic        wr_ready;
    reg_wr_t     wr;
    logic        rt_valid;
    logic        rt_ready;
    rt_quad_t    rt;
    logic        rd_valid;
    logic        rd_ready;
    rd_req_t     rd;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_data;
    logic        ext_wen;
    reg_wr_t     ext_wr;
    logic [15:0] ext_raddr;
    logic [31:0] ext_rdata;
    logic        wdog_clear;
    logic        wdog_timeout;

    logic [15:0] ext_match;                     // address the channel model answers
    logic [31:0] ext_value;
    integer      seed = 51395;
    int          limit_cycles = 0;              // 0 until the test list is loaded

    byte         op_q[$];                       // test list with one entry per data line
    logic [15:0] arg_q[$];
    logic [31:0] dat_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] rsp_exp_q[$];                  // reads in flight
    string       rsp_name_q[$];
    reg_wr_t     ext_seen_q[$];                 // external writes not yet checked

    reg_bus_core UUT (
        .sysclk       (sysclk),
        .rst          (rst),
        .board_id     (BOARD_ID),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr           (wr),
        .rt_valid     (rt_valid),
        .rt_ready     (rt_ready),
        .rt           (rt),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd           (rd),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data),
        .ext_wen      (ext_wen),
        .ext_wr       (ext_wr),
        .ext_raddr    (ext_raddr),
        .ext_rdata    (ext_rdata),
        .wdog_clear   (wdog_clear),
        .wdog_timeout (wdog_timeout)
    );

    // channel model answers other addresses with an address-derived fill
    assign ext_rdata = (ext_raddr == ext_match) ? ext_value : {~ext_raddr, ext_raddr};

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;            // 4 ns period
    end

    // ------------------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_raddr(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_wr(input string name, input reg_wr_t exp, input reg_wr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h/%h, actual %h/%h", name,
                     exp.addr, exp.data, act.addr, act.data);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // pages other than main and hub, or main-page channels above 0
    function automatic logic goes_off_board(input logic [15:0] addr);
        return ((addr[15:12] != 4'd0) && (addr[15:12] != 4'd2))
               || ((addr[15:12] == 4'd0) && (addr[7:4] != 4'd0));
    endfunction

    task automatic expect_ext_write(input string name, input reg_wr_t exp);
        if (ext_seen_q.size() == 0) begin
            $display("%s: no external write was seen", name);
            stop_with_failure();
        end else begin
            check_wr(name, exp, ext_seen_q.pop_front());
        end
    endtask

    // ------------------------------------------------------------------------
    // bus operations start and end 0.5 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic finish_host_write();
        @(negedge sysclk);
        while (!wr_ready) @(negedge sysclk);
        @(posedge sysclk);                      // transfer edge
        #0.5;
        wr_valid = 1'b0;
    endtask

    task automatic host_write(input string name, input logic [15:0] addr,
                              input logic [31:0] data);
        reg_wr_t exp;
        exp.addr = addr;
        exp.data = data;
        wr_valid = 1'b1;
        wr       = exp;
        finish_host_write();
        if (goes_off_board(addr))
            expect_ext_write(name, exp);
    endtask

    task automatic host_read(input string name, input rd_req_t req, input logic [31:0] value,
                             input logic [31:0] exp, input logic check_addr,
                             input logic [15:0] exp_addr);
        rd_valid  = 1'b1;
        rd        = req;
        ext_match = check_addr ? exp_addr : req.addr;
        ext_value = value;
        @(negedge sysclk);
        while (!rd_ready) @(negedge sysclk);
        if (check_addr)
            check_raddr({name, " ext_raddr"}, exp_addr, ext_raddr);
        @(posedge sysclk);                      // request accepted here
        rsp_exp_q.push_back(exp);
        rsp_name_q.push_back(name);
        #0.5;
        rd_valid = 1'b0;
    endtask

    // quadlet stream with a scratch write queued behind the first motor write
    task automatic rt_block(input string name, input int cnt, input logic [31:0] base,
                            input logic [31:0] hdata);
        reg_wr_t exp;
        logic    host_done;
        int      k;
        for (k = 0; k < cnt; k++) begin
            rt_valid = 1'b1;
            rt.data  = base + k;
            rt.last  = (k == cnt - 1);
            if (k == 1) begin
                wr_valid = 1'b1;
                wr.addr  = {12'h000, REG_SCRATCH};
                wr.data  = hdata;
            end
            @(negedge sysclk);
            while (!rt_ready) @(negedge sysclk);
            host_done = wr_valid && wr_ready;
            @(posedge sysclk);
            #0.5;
            if (host_done)
                wr_valid = 1'b0;
        end
        rt_valid = 1'b0;
        rt.last  = 1'b0;
        if (wr_valid)
            finish_host_write();
        @(posedge sysclk);                      // let the last motor write pass
        #0.5;
        for (k = 0; k < cnt && k < NUM_MOTORS; k++) begin
            exp.addr = {8'h00, 4'(k + 1), REG_DAC};     // quadlet k -> channel k+1
            exp.data = base + k;
            expect_ext_write($sformatf("%s quadlet %0d", name, k), exp);
        end
        if (ext_seen_q.size() != 0) begin
            $display("%s: the block produced more external writes than motors", name);
            stop_with_failure();
        end
    endtask

    task automatic watchdog_step(input string name, input int cycles, input logic pulse,
                                 input logic exp);
        if (pulse) begin
            wdog_clear = 1'b1;
            @(posedge sysclk);
            #0.5;
            wdog_clear = 1'b0;
        end
        repeat (cycles) @(posedge sysclk);
        @(negedge sysclk);
        check_flag(name, exp, wdog_timeout);
        @(posedge sysclk);
        #0.5;
    endtask

    task automatic load_tests();
        int                 fd;
        int                 code;
        byte                op;
        logic [15:0]        arg;
        logic [31:0]        dat;
        logic [31:0]        exp;
        logic [8*200-1:0]   rest;
        fd = $fopen("tb/reg_bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            stop_with_failure();
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);    // skip a comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h", arg, dat, exp);
                    if (code != 3) begin
                        $display("malformed line in the test data file");
                        stop_with_failure();
                    end else begin
                        op_q.push_back(op);
                        arg_q.push_back(arg);
                        dat_q.push_back(dat);
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // background processes
    // ------------------------------------------------------------------------
    always @(posedge sysclk) begin
        #0.5;
        rsp_ready = ($random(seed) & 3) != 0;   // stalls about one cycle in four
    end

    always @(negedge sysclk) begin
        if (!rst && ext_wen)
            ext_seen_q.push_back(ext_wr);
    end

    always @(negedge sysclk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            if (rsp_exp_q.size() == 0) begin
                $display("a read response arrived with no read outstanding");
                stop_with_failure();
            end else begin
                check_data(rsp_name_q.pop_front(), rsp_exp_q.pop_front(), rsp_data);
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sysclk);
        $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
        stop_with_failure();
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int      i;
        int      max_wait;
        string   name;
        rd_req_t req;
        rst        = 1'b1;
        wr_valid   = 1'b0;
        wr         = '0;
        rt_valid   = 1'b0;
        rt         = '0;
        rd_valid   = 1'b0;
        rd         = '0;
        rsp_ready  = 1'b1;
        wdog_clear = 1'b0;
        ext_match  = 16'hffff;
        ext_value  = 32'd0;
        max_wait   = 0;

        load_tests();
        for (i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "X" && arg_q[i] > max_wait)
                max_wait = arg_q[i];
        end
        limit_cycles = op_q.size() * 200 + max_wait;

        repeat (2) @(posedge sysclk);
        #0.5;
        rst = 1'b0;
        @(negedge sysclk);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset ext_wen", 1'b0, ext_wen);
        check_flag("reset wdog_timeout", 1'b0, wdog_timeout);
        check_flag("reset wr_ready", 1'b1, wr_ready);
        check_flag("reset rd_ready", 1'b1, rd_ready);
        check_flag("reset rt_ready", 1'b1, rt_ready);
        @(posedge sysclk);
        #0.5;

        for (i = 0; i < op_q.size(); i++) begin
            name = $sformatf("line %0d %c %h", i + 1, op_q[i], arg_q[i]);
            case (op_q[i])
                "W": host_write(name, arg_q[i], dat_q[i]);
                "R": begin
                    req.addr   = arg_q[i];
                    req.blk_rt = 1'b0;
                    host_read(name, req, dat_q[i], exp_q[i], 1'b0, 16'd0);
                end
                "B": begin
                    req.addr   = arg_q[i];      // block index
                    req.blk_rt = 1'b1;
                    host_read(name, req, dat_q[i], dat_q[i], 1'b1, exp_q[i][15:0]);
                end
                "T": rt_block(name, arg_q[i], dat_q[i], exp_q[i]);
                "X": watchdog_step(name, arg_q[i], dat_q[i][0], exp_q[i][0]);
                default: begin
                    $display("%s: unknown opcode in the test data file", name);
                    stop_with_failure();
                end
            endcase
        end

        while (rsp_exp_q.size() != 0) @(posedge sysclk);
        repeat (4) @(posedge sysclk);           // any late duplicate shows up here
        if (ext_seen_q.size() != 0) begin
            $display("external writes appeared that no test expected");
            stop_with_failure();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* tb/reg_bus_testdata.txt */
# op addr_or_index data expected, all hex; W write, R read (data = ext_rdata), B block read
# T rt block (addr = quadlets, expected = scratch write), X watchdog (addr = cycles, data 1 = clear)
W 0003 cafef00d 00000000
R 0003 00000000 cafef00d
R 0001 00000000 00000007
R 0000 00000000 0a000000
R 200f 00000000 00000000
T 0004 11110000 5a5a0001
R 0003 00000000 5a5a0001
R 200f 00000000 00000001
T 0006 22220000 5a5a0002
R 0003 00000000 5a5a0002
R 200f 00000000 00000002
W 0025 abcd0025 00000000
R 0025 13572468 13572468
W 2000 c0de0000 00000000
W 2001 c0de0011 00000000
W 2002 c0de0022 00000000
W 2003 c0de0033 00000000
W 2004 c0de0044 00000000
W 2005 c0de0055 00000000
W 2006 c0de0066 00000000
W 2007 c0de0077 00000000
W 2008 c0de0088 00000000
W 2009 c0de0099 00000000
W 200a c0de00aa 00000000
W 200b c0de00bb 00000000
W 200c c0de00cc 00000000
W 200d c0de00dd 00000000
W 200e c0de00ee 00000000
R 2000 00000000 c0de0000
R 2001 00000000 c0de0011
R 2002 00000000 c0de0022
R 2003 00000000 c0de0033
R 2004 00000000 c0de0044
R 2005 00000000 c0de0055
R 2006 00000000 c0de0066
R 2007 00000000 c0de0077
R 2008 00000000 c0de0088
R 2009 00000000 c0de0099
R 200a 00000000 c0de00aa
R 200b 00000000 c0de00bb
R 200c 00000000 c0de00cc
R 200d 00000000 c0de00dd
R 200e 00000000 c0de00ee
B 0000 0a000000 00000000
B 0004 44440004 00000011
B 000b 4444000b 00000042
B 000c 4444000c 00000014
B 001f 4444001f 00000048
W 0002 00000002 00000000
X 0014 00000000 00000000
X 0014 00000000 00000001
W 0000 00000000 00000000
X 0001 00000000 00000000
X 0028 00000000 00000001
X 0001 00000001 00000000
W 0002 00000000 00000000

/* vlog.f */
hdl/fpga_bus_pkg.sv
hdl/rt_write_unpack.sv
hdl/write_bus_arbiter.sv
hdl/read_addr_xlate.sv
hdl/board_regs.sv
hdl/hub_regs.sv
hdl/reg_bus_core.sv
tb/reg_bus_core_tb.sv

/* Bender.yml */
package:
  name: reg_bus_core

sources:
  - files:
      - hdl/fpga_bus_pkg.sv
      - hdl/rt_write_unpack.sv
      - hdl/write_bus_arbiter.sv
      - hdl/read_addr_xlate.sv
      - hdl/board_regs.sv
      - hdl/hub_regs.sv
      - hdl/reg_bus_core.sv
  - target: test
    files:
      - tb/reg_bus_core_tb.sv
